/* vic_pkg.sv */
package vic_pkg;

    typedef enum logic [1:0] {
        CHIP6567R8   = 2'd0,
        CHIP6567R56A = 2'd1,
        CHIP6569     = 2'd2,
        CHIPUNUSED   = 2'd3  // treated as 6569
    } vic_chip_t;

    typedef enum logic [3:0] {
        BLACK, WHITE, RED, CYAN, PURPLE, GREEN, BLUE, YELLOW,
        ORANGE, BROWN, PINK, DARK_GREY, GREY, LIGHT_GREEN, LIGHT_BLUE, LIGHT_GREY
    } vic_color_t;

    typedef enum logic [1:0] {
        REG_CTRL       = 2'd0,
        REG_BORDER     = 2'd1,
        REG_BACKGROUND = 2'd2,
        REG_RASTER     = 2'd3  // read only
    } vic_reg_addr_t;

    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
    } raster_t;

    typedef struct packed {
        logic [9:0] pixels_per_line;
        logic [8:0] lines_per_frame;
        logic [9:0] hsync_start;
        logic [9:0] hsync_end;
        logic [9:0] hvisible_start;
        logic [8:0] vblank_start;
        logic [8:0] vblank_end;
    } chip_timing_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;
        logic [7:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat_r;
    } wb_rsp_t;

    // pulse widths in pixels
    localparam logic [9:0] EQ_WIDTH   = 10'd18;
    localparam logic [9:0] SERR_WIDTH = 10'd37;

    // display window, inclusive
    localparam logic [9:0] DISP_X0 = 10'd24;
    localparam logic [9:0] DISP_X1 = 10'd343;
    localparam logic [8:0] DISP_Y0 = 9'd51;
    localparam logic [8:0] DISP_Y1 = 9'd250;

    function automatic chip_timing_t chip_timing(input vic_chip_t chip);
        chip_timing_t t;
        case (chip)
            CHIP6567R8:
            begin
                t = '{pixels_per_line: 10'd520, lines_per_frame: 9'd263,
                      hsync_start: 10'd409, hsync_end: 10'd446, hvisible_start: 10'd497,
                      vblank_start: 9'd14, vblank_end: 9'd22};
            end
            CHIP6567R56A:
            begin
                t = '{pixels_per_line: 10'd512, lines_per_frame: 9'd262,
                      hsync_start: 10'd409, hsync_end: 10'd446, hvisible_start: 10'd497,
                      vblank_start: 9'd14, vblank_end: 9'd22};
            end
            default: // 6569 and the unused code, PAL timing
            begin
                t = '{pixels_per_line: 10'd504, lines_per_frame: 9'd312,
                      hsync_start: 10'd408, hsync_end: 10'd444, hvisible_start: 10'd492,
                      vblank_start: 9'd301, vblank_end: 9'd309};
            end
        endcase
        return t;
    endfunction

endpackage

/* vic_regs.sv */
module vic_regs
    import vic_pkg::*;
#(
    parameter vic_chip_t DEFAULT_CHIP = CHIP6569
)
(
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    input  logic [8:0] raster_y,
    output vic_chip_t  chip,
    output logic       display_en,
    output vic_color_t border_color,
    output vic_color_t background_color
);

    logic          ack;
    logic [7:0]    dat_r;
    logic          strobe;      // accepted this cycle
    vic_reg_addr_t addr;
    logic [7:0]    rd_value;

    // a second ack is never raised back to back
    assign strobe = wb_req.cyc && wb_req.stb && !ack;
    assign addr   = vic_reg_addr_t'(wb_req.adr);

    always_comb
    begin
        case (addr)
            REG_CTRL:       rd_value = {5'b0, display_en, chip};
            REG_BORDER:     rd_value = {4'b0, border_color};
            REG_BACKGROUND: rd_value = {4'b0, background_color};
            default:        rd_value = raster_y[7:0]; // raster line, low byte
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack              <= 1'b0;
            chip             <= DEFAULT_CHIP;
            display_en       <= 1'b0;
            border_color     <= BLACK;
            background_color <= BLACK;
        end
        else
        begin
            ack <= strobe;
            if (strobe && wb_req.we)
            begin
                case (addr)
                    REG_CTRL:
                    begin
                        chip       <= vic_chip_t'(wb_req.dat_w[1:0]);
                        display_en <= wb_req.dat_w[2];
                    end
                    REG_BORDER:     border_color     <= vic_color_t'(wb_req.dat_w[3:0]);
                    REG_BACKGROUND: background_color <= vic_color_t'(wb_req.dat_w[3:0]);
                    default:        ; // raster is read only
                endcase
            end
        end
    end

    // read data lands with ack
    always_ff @(posedge clk)
    begin
        if (strobe)
            dat_r <= rd_value;
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = dat_r;

endmodule

/* raster_counter.sv */
module raster_counter
    import vic_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  vic_chip_t chip,
    output raster_t   raster
);

    chip_timing_t timing;
    logic         end_of_line;
    logic         end_of_frame;

    assign timing = chip_timing(chip);

    // >= so a switch to a shorter chip still wraps cleanly
    assign end_of_line  = raster.x >= timing.pixels_per_line - 10'd1;
    assign end_of_frame = raster.y >= timing.lines_per_frame - 9'd1;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            raster <= '0;
        end
        else if (end_of_line)
        begin
            raster.x <= '0;
            if (end_of_frame)
                raster.y <= '0;
            else
                raster.y <= raster.y + 9'd1;
        end
        else
        begin
            raster.x <= raster.x + 10'd1; // one pixel per clock
        end
    end

endmodule

/* pixel_source.sv */
module pixel_source
    import vic_pkg::*;
(
    input  raster_t    raster,
    input  logic       display_en,
    input  vic_color_t border_color,
    input  vic_color_t background_color,
    output vic_color_t pixel_color3
);

    logic in_x;
    logic in_y;
    logic in_window;

    assign in_x      = raster.x >= DISP_X0 && raster.x <= DISP_X1;
    assign in_y      = raster.y >= DISP_Y0 && raster.y <= DISP_Y1;
    assign in_window = in_x && in_y;

    // with display off the whole screen is border
    always_comb
    begin
        if (in_window && display_en)
            pixel_color3 = background_color;
        else
            pixel_color3 = border_color;
    end

endmodule

/* equalization_pulse.sv */
module equalization_pulse
    import vic_pkg::*;
(
    input  logic [9:0] raster_x,
    input  vic_chip_t  chip,
    output logic       eq
);

    chip_timing_t timing;
    logic [10:0]  ppl;
    logic [10:0]  second;     // start of the mid-line pulse
    logic [10:0]  off_first;
    logic [10:0]  off_second;

    assign timing = chip_timing(chip);
    assign ppl    = {1'b0, timing.pixels_per_line};

    always_comb
    begin
        second = {1'b0, timing.hsync_start} + {2'b0, timing.pixels_per_line[9:1]};
        if (second >= ppl)
            second = second - ppl; // wraps into the next line start

        // distance from each pulse start, modulo the line length
        if (raster_x >= timing.hsync_start)
            off_first = {1'b0, raster_x} - {1'b0, timing.hsync_start};
        else
            off_first = {1'b0, raster_x} + ppl - {1'b0, timing.hsync_start};

        if ({1'b0, raster_x} >= second)
            off_second = {1'b0, raster_x} - second;
        else
            off_second = {1'b0, raster_x} + ppl - second;

        eq = off_first < {1'b0, EQ_WIDTH} || off_second < {1'b0, EQ_WIDTH};
    end

endmodule

/* serration_pulse.sv */
module serration_pulse
    import vic_pkg::*;
(
    input  logic [9:0] raster_x,
    input  vic_chip_t  chip,
    output logic       se
);

    chip_timing_t timing;
    logic [10:0]  ppl;
    logic [10:0]  half;
    logic [10:0]  width;   // wide pulse, half line less the serration gap
    logic [10:0]  second;
    logic [10:0]  off_first;
    logic [10:0]  off_second;

    assign timing = chip_timing(chip);
    assign ppl    = {1'b0, timing.pixels_per_line};
    assign half   = {2'b0, timing.pixels_per_line[9:1]};
    assign width  = half - {1'b0, SERR_WIDTH};

    always_comb
    begin
        second = {1'b0, timing.hsync_start} + half;
        if (second >= ppl)
            second = second - ppl;

        if (raster_x >= timing.hsync_start)
            off_first = {1'b0, raster_x} - {1'b0, timing.hsync_start};
        else
            off_first = {1'b0, raster_x} + ppl - {1'b0, timing.hsync_start};

        if ({1'b0, raster_x} >= second)
            off_second = {1'b0, raster_x} - second;
        else
            off_second = {1'b0, raster_x} + ppl - second;

        se = off_first < width || off_second < width;
    end

endmodule

/* comp_sync.sv */
module comp_sync
    import vic_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  vic_chip_t  chip,
    input  raster_t    raster,
    input  vic_color_t pixel_color3,
    output logic       csync,
    output vic_color_t pixel_color4
);

    chip_timing_t timing;
    logic         eq;
    logic         se;
    logic         h_active;
    logic         v_active;
    logic         hsync;        // high inside the sync tip
    logic [8:0]   vline;        // line offset into vertical blanking
    logic         in_vsync;
    logic         csync_next;

    assign timing = chip_timing(chip);

    equalization_pulse eq_pulse0
    (
        .raster_x (raster.x),
        .chip     (chip),
        .eq       (eq)
    );

    serration_pulse se_pulse0
    (
        .raster_x (raster.x),
        .chip     (chip),
        .se       (se)
    );

    // black outside the active area
    assign h_active     = raster.x < timing.hsync_start || raster.x > timing.hvisible_start;
    assign v_active     = raster.y < timing.vblank_start || raster.y > timing.vblank_end;
    assign pixel_color4 = (h_active && v_active) ? pixel_color3 : BLACK;

    assign hsync    = raster.x >= timing.hsync_start && raster.x <= timing.hsync_end;
    assign vline    = raster.y - timing.vblank_start;
    assign in_vsync = raster.y >= timing.vblank_start && vline < 9'd9;

    always_comb
    begin
        if (!in_vsync)
            csync_next = !hsync;
        else if (vline < 9'd3)
            csync_next = !eq;   // pre-equalization
        else if (vline < 9'd6)
            csync_next = !se;   // vertical sync, serrated
        else
            csync_next = !eq;   // post-equalization
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            csync <= 1'b0;
        else
            csync <= csync_next;
    end

endmodule

/* video_out_top.sv */
module video_out_top
    import vic_pkg::*;
#(
    parameter vic_chip_t DEFAULT_CHIP = CHIP6569
)
(
    input  logic       clk,
    input  logic       rst,
    input  wb_req_t    wb_req,
    output wb_rsp_t    wb_rsp,
    output logic       csync,
    output vic_color_t pixel_color,
    output raster_t    raster
);

    vic_chip_t  chip;
    logic       display_en;
    vic_color_t border_color;
    vic_color_t background_color;
    vic_color_t pixel_color3;

    vic_regs #(
        .DEFAULT_CHIP (DEFAULT_CHIP)
    ) regs0 (
        .clk              (clk),
        .rst              (rst),
        .wb_req           (wb_req),
        .wb_rsp           (wb_rsp),
        .raster_y         (raster.y),
        .chip             (chip),
        .display_en       (display_en),
        .border_color     (border_color),
        .background_color (background_color)
    );

    raster_counter raster0
    (
        .clk    (clk),
        .rst    (rst),
        .chip   (chip),
        .raster (raster)
    );

    pixel_source pixel0
    (
        .raster           (raster),
        .display_en       (display_en),
        .border_color     (border_color),
        .background_color (background_color),
        .pixel_color3     (pixel_color3)
    );

    comp_sync sync0
    (
        .clk          (clk),
        .rst          (rst),
        .chip         (chip),
        .raster       (raster),
        .pixel_color3 (pixel_color3),
        .csync        (csync),
        .pixel_color4 (pixel_color)
    );

endmodule

/* tb_video_out.sv */
module tb_video_out
    import vic_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // three frames take about 428k cycles, the rest is margin for the chip switches
    localparam int TIMEOUT_CYCLES = 600000;

    logic       clk = 1'b0;
    logic       rst;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       csync;
    vic_color_t pixel_color;
    raster_t    raster;

    int         mx;                  // reference raster
    int         my;
    logic       exp_csync;
    vic_chip_t  m_chip   = CHIP6569;
    logic       m_disp   = 1'b0;
    vic_color_t m_border = BLACK;
    vic_color_t m_bg     = BLACK;

    int         errors = 0;
    int         passed = 0;
    int         failed = 0;
    int         cycles = 0;
    int         test_errors;
    string      test_name;
    int         strobe_y;            // reference line seen by the accepting edge

    video_out_top dut0 (.*);

    always #5 clk = ~clk;

    // ppl, lines, hsync start/end, hvisible start, vblank start/end
    function automatic chip_timing_t timing_of(input vic_chip_t c);
        case (c)
            CHIP6567R8:   return '{10'd520, 9'd263, 10'd409, 10'd446, 10'd497, 9'd14, 9'd22};
            CHIP6567R56A: return '{10'd512, 9'd262, 10'd409, 10'd446, 10'd497, 9'd14, 9'd22};
            default:      return '{10'd504, 9'd312, 10'd408, 10'd444, 10'd492, 9'd301, 9'd309};
        endcase
    endfunction

    function automatic logic in_pulse(input int x, input int start, input int width, input int ppl);
        return ((x - start + ppl) % ppl) < width; // distance modulo the line
    endfunction

    function automatic logic csync_of(input int x, input int y, input vic_chip_t c);
        chip_timing_t t;
        int ppl;
        int hs;
        int vl;
        logic eq;
        logic se;
        t   = timing_of(c);
        ppl = int'(t.pixels_per_line);
        hs  = int'(t.hsync_start);
        vl  = y - int'(t.vblank_start);
        eq  = in_pulse(x, hs, int'(EQ_WIDTH), ppl)
              || in_pulse(x, (hs + ppl / 2) % ppl, int'(EQ_WIDTH), ppl);
        se  = in_pulse(x, hs, ppl / 2 - int'(SERR_WIDTH), ppl)
              || in_pulse(x, (hs + ppl / 2) % ppl, ppl / 2 - int'(SERR_WIDTH), ppl);
        if ((vl >= 0 && vl < 3) || (vl >= 6 && vl < 9))
            return !eq;
        if (vl >= 3 && vl < 6)
            return !se;
        return !(x >= hs && x <= int'(t.hsync_end));
    endfunction

    function automatic vic_color_t color_of(input int x, input int y, input vic_chip_t c);
        chip_timing_t t;
        logic active;
        logic window;
        t      = timing_of(c);
        active = (x < int'(t.hsync_start) || x > int'(t.hvisible_start))
                 && (y < int'(t.vblank_start) || y > int'(t.vblank_end));
        window = x >= int'(DISP_X0) && x <= int'(DISP_X1) && y >= int'(DISP_Y0)
                 && y <= int'(DISP_Y1);
        if (!active)
            return BLACK;
        return (window && m_disp) ? m_bg : m_border;
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errors)
        begin
            passed++;
            $display("test %s: pass", test_name);
        end
        else
        begin
            failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic wb_transfer(input logic we, input vic_reg_addr_t adr, input logic [7:0] dat_w,
                               output logic [7:0] dat_r);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        wb_req   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat_w};
        strobe_y = my;
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while (!wb_rsp.ack && waited < 16);
        dat_r = wb_rsp.dat_r;
        if (!wb_rsp.ack)
        begin
            $display("wishbone transfer to address %0d never got an ack", adr);
            errors++;
        end
        else if (we)
        begin
            case (adr)   // write landed on the edge that raised ack
                REG_CTRL:
                begin
                    m_chip = vic_chip_t'(dat_w[1:0]);
                    m_disp = dat_w[2];
                end
                REG_BORDER:     m_border = vic_color_t'(dat_w[3:0]);
                REG_BACKGROUND: m_bg     = vic_color_t'(dat_w[3:0]);
                default:        ;
            endcase
        end
        else if (adr == REG_RASTER)
        begin
            // low byte of the line the raster was on at the strobe
            assert (dat_r == strobe_y[7:0])
            else report_mismatch("wb_rsp.dat_r", strobe_y % 256, int'(dat_r));
        end
        assert (waited == 1) else report_mismatch("ack delay", 1, waited);
        wb_req = '0;
        @(posedge clk);
        #1;
        assert (!wb_rsp.ack) else report_mismatch("wb_rsp.ack", 0, int'(wb_rsp.ack));
    endtask

    task automatic wb_write(input vic_reg_addr_t adr, input logic [7:0] dat_w);
        logic [7:0] unused;
        wb_transfer(1'b1, adr, dat_w, unused);
    endtask

    task automatic wb_read(input vic_reg_addr_t adr, input logic [7:0] expected);
        logic [7:0] dat_r;
        wb_transfer(1'b0, adr, 8'h00, dat_r);
        assert (dat_r == expected) else report_mismatch("wb_rsp.dat_r", int'(expected), int'(dat_r));
    endtask

    task automatic wait_raster(input int x, input int y);
        do
        begin
            @(posedge clk);
            #1;
        end
        while (!(mx == x && my == y));
    endtask

    always @(posedge clk)
    begin : model_step
        chip_timing_t t;
        t = timing_of(m_chip);
        if (rst)
        begin
            mx        <= 0;
            my        <= 0;
            exp_csync <= 1'b0;
        end
        else
        begin
            exp_csync <= csync_of(mx, my, m_chip); // registered, last cycle's raster
            if (mx >= int'(t.pixels_per_line) - 1)
            begin
                mx <= 0;
                my <= (my >= int'(t.lines_per_frame) - 1) ? 0 : my + 1;
            end
            else
                mx <= mx + 1;
        end
    end

    always @(negedge clk)
    begin : check_outputs
        vic_color_t want;
        want = color_of(mx, my, m_chip);
        if (rst)
        begin
            assert (!csync) else report_mismatch("csync", 0, int'(csync));
            assert (!wb_rsp.ack) else report_mismatch("wb_rsp.ack", 0, int'(wb_rsp.ack));
            assert (raster == '0) else report_mismatch("raster", 0, int'(raster));
        end
        else
        begin
            assert (int'(raster.x) == mx) else report_mismatch("raster.x", mx, int'(raster.x));
            assert (int'(raster.y) == my) else report_mismatch("raster.y", my, int'(raster.y));
            assert (csync == exp_csync) else report_mismatch("csync", int'(exp_csync), int'(csync));
            assert (pixel_color == want)
            else report_mismatch("pixel_color", int'(want), int'(pixel_color));
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] rnd;
        vic_color_t  border;
        vic_color_t  background;
        rnd    = $urandom(32'hb73eef60);  // seeds the generator
        rst    = 1'b1;
        wb_req = '0;

        start_test("reset state");
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        wb_read(REG_CTRL, {5'b0, 1'b0, CHIP6569});
        finish_test();

        start_test("register access");
        rnd        = $urandom();
        border     = vic_color_t'(rnd[3:0]);
        if (border == BLACK)
            border = WHITE;   // border must stand out from the blanking
        background = vic_color_t'(rnd[7:4]);
        if (background == border)
            background = vic_color_t'(~border);
        wb_write(REG_BORDER, {rnd[11:8], border});   // junk in the unused bits
        wb_write(REG_BACKGROUND, {rnd[15:12], background});
        wb_write(REG_CTRL, {rnd[20:16], 1'b1, CHIP6569});
        wb_write(REG_RASTER, rnd[31:24]);
        wb_read(REG_BORDER, {4'h0, border});
        wb_read(REG_BACKGROUND, {4'h0, background});
        wb_read(REG_CTRL, {5'b0, 1'b1, CHIP6569});
        wb_read(REG_RASTER, 8'h00);
        finish_test();

        start_test("frame CHIP6569 display on");
        wait_raster(0, 280);                         // above 255, low byte only
        wb_read(REG_RASTER, 8'd24);
        wait_raster(0, 0);
        finish_test();

        start_test("frame CHIP6567R8 switched mid-line");
        wait_raster(200, 0);
        wb_write(REG_CTRL, {5'b0, 1'b1, CHIP6567R8});
        wait_raster(0, 100);
        wb_read(REG_RASTER, 8'd100);
        wait_raster(0, 0);
        finish_test();

        start_test("frame CHIP6567R56A display off");
        wait_raster(200, 0);
        wb_write(REG_CTRL, {5'b0, 1'b0, CHIP6567R56A});
        wait_raster(0, 0);
        finish_test();

        $display("tests run: %0d, passed: %0d, failed: %0d", passed + failed, passed, failed);
        if (failed == 0 && errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* video_out_top.f */
vic_pkg.sv
vic_regs.sv
raster_counter.sv
pixel_source.sv
equalization_pulse.sv
serration_pulse.sv
comp_sync.sv
video_out_top.sv
tb_video_out.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_video_out
FILELIST  ?= video_out_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= All tests passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
